// ==== valu.f ====
+incdir+common
+incdir+tests
common/valu_pkg.sv
rtl/valu_decode.sv
arith/valu_add_min_max.sv
rtl/valu_bitwise_unit.sv
rtl/valu_tag_pipe.sv
rtl/valu_resp_merge.sv
rtl/valu.sv
tests/valu_tb.sv

// ==== Bender.yml ====
package:
  name: valu

sources:
  - include_dirs:
      - common
    files:
      - common/valu_pkg.sv
      - rtl/valu_decode.sv
      - arith/valu_add_min_max.sv
      - rtl/valu_bitwise_unit.sv
      - rtl/valu_tag_pipe.sv
      - rtl/valu_resp_merge.sv
      - rtl/valu.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/valu_tb.sv

// ==== tests/valu_ref_model.svh ====
`ifndef VALU_REF_MODEL_SVH
`define VALU_REF_MODEL_SVH

function automatic logic is_legal_func(input logic [`VALU_FUNC_W-1:0] func);
    case (func)
        FUNC_ADD, FUNC_SUB, FUNC_MINU, FUNC_MIN, FUNC_MAXU, FUNC_MAX,
        FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_MV_MERGE: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic is_arith_func(input logic [`VALU_FUNC_W-1:0] func);
    return (func <= FUNC_MAX);  // codes 0x00 to 0x07 live in the arith unit
endfunction

// one element, w bits wide, zero-extended into 64 bits
function automatic logic [63:0] lane_arith(input logic [`VALU_FUNC_W-1:0] func, input int w,
                                          input logic [63:0] ea, input logic [63:0] eb);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = ea << (64 - w);
    sa = sa >>> (64 - w);  // sign extend from the element top bit
    sb = eb << (64 - w);
    sb = sb >>> (64 - w);
    case (func)
        FUNC_ADD:  return ea + eb;
        FUNC_SUB:  return ea - eb;
        FUNC_MINU: return (ea < eb) ? ea : eb;
        FUNC_MIN:  return (sa < sb) ? ea : eb;
        FUNC_MAXU: return (ea < eb) ? eb : ea;
        FUNC_MAX:  return (sa < sb) ? eb : ea;
        default:   return 64'd0;
    endcase
endfunction

function automatic logic [`VALU_DATA_W-1:0] model_arith(input logic [`VALU_FUNC_W-1:0] func,
        input logic [1:0] sew, input logic [`VALU_DATA_W-1:0] a,
        input logic [`VALU_DATA_W-1:0] b);
    int          w;
    logic [63:0] emask;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] res;
    w     = 8 << sew;
    emask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
    res   = '0;
    for (int l = 0; l < 64 / w; l++) begin
        ea  = (a >> (l * w)) & emask;
        eb  = (b >> (l * w)) & emask;
        res = res | ((lane_arith(func, w, ea, eb) & emask) << (l * w));  // wrap inside lane
    end
    return res;
endfunction

function automatic logic [`VALU_DATA_W-1:0] model_bitwise(input logic [`VALU_FUNC_W-1:0] func,
        input logic mask, input logic [`VALU_BE_W-1:0] be,
        input logic [`VALU_DATA_W-1:0] a, input logic [`VALU_DATA_W-1:0] b);
    logic [`VALU_DATA_W-1:0] res;
    case (func)
        FUNC_AND: res = a & b;
        FUNC_OR:  res = a | b;
        FUNC_XOR: res = a ^ b;
        default:  res = a;  // move
    endcase
    if (func == FUNC_MV_MERGE && mask) begin
        for (int i = 0; i < `VALU_BE_W; i++) begin
            if (be[i])
                res[8*i +: 8] = b[8*i +: 8];
        end
    end
    return res;
endfunction

`endif

// ==== tests/valu_tb.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_tb;
    import valu_pkg::*;

    `include "valu_ref_model.svh"

    localparam int N_REQ       = 400;
    localparam int CYCLE_LIMIT = N_REQ + 20;

    typedef struct packed {
        logic                    valid;
        logic [`VALU_DATA_W-1:0] data;
        logic [`VALU_ADDR_W-1:0] addr;
        logic [`VALU_VL_W-1:0]   vl;
        logic [`VALU_BE_W-1:0]   be;
    } resp_t;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    logic [`VALU_FUNC_W-1:0] req_func_id;
    sew_t                    req_sew;
    logic                    req_mask;
    logic [`VALU_DATA_W-1:0] req_data0;
    logic [`VALU_DATA_W-1:0] req_data1;
    logic [`VALU_ADDR_W-1:0] req_addr;
    logic [`VALU_VL_W-1:0]   req_vl;
    logic [`VALU_BE_W-1:0]   req_be;
    logic                    resp_valid;
    logic [`VALU_DATA_W-1:0] resp_data;
    logic [`VALU_ADDR_W-1:0] resp_addr;
    logic [`VALU_VL_W-1:0]   resp_vl;
    logic [`VALU_BE_W-1:0]   resp_be;

    logic [31:0] rng_state;
    resp_t       exp_q[$];  // one entry per edge, valid or not
    int          errors      = 0;
    int          cycle_count = 0;

    valu UUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_mask    (req_mask),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_vl      (req_vl),
        .req_be      (req_be),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_vl     (resp_vl),
        .resp_be     (resp_be)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ten legal codes and four that decode to no unit
    function automatic logic [`VALU_FUNC_W-1:0] pick_func(input logic [31:0] r);
        case (r % 14)
            0:       return FUNC_ADD;
            1:       return FUNC_SUB;
            2:       return FUNC_MINU;
            3:       return FUNC_MIN;
            4:       return FUNC_MAXU;
            5:       return FUNC_MAX;
            6:       return FUNC_AND;
            7:       return FUNC_OR;
            8:       return FUNC_XOR;
            9:       return FUNC_MV_MERGE;
            10:      return 6'h01;
            11:      return 6'h0C;
            12:      return 6'h1F;
            default: return 6'h3F;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors = errors + 1;
            $display("Something failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic drive_idle();
        req_valid   = 1'b0;
        req_func_id = '0;
        req_sew     = '0;
        req_mask    = 1'b0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_vl      = '0;
        req_be      = '0;
    endtask

    task automatic drive_random();
        logic [31:0] ctl;
        logic [31:0] hi;
        logic [31:0] lo;
        ctl         = next_rand();
        req_valid   = (ctl[2:0] != 3'd0);  // some idle cycles
        req_func_id = pick_func(next_rand());
        req_sew     = ctl[4:3];
        req_mask    = ctl[5];
        hi          = next_rand();
        lo          = next_rand();
        req_data0   = {hi, lo};
        hi          = next_rand();
        lo          = next_rand();
        req_data1   = (ctl[8:6] == 3'd0) ? req_data0 : {hi, lo};  // equal lanes now and then
        req_addr    = next_rand();
        req_vl      = ctl[15:8];
        req_be      = ctl[23:16];
    endtask

    task automatic push_expected();
        resp_t e;
        e.valid = req_valid && is_legal_func(req_func_id);
        e.addr  = req_addr;
        e.vl    = req_vl;
        e.be    = req_be;
        if (is_arith_func(req_func_id))
            e.data = model_arith(req_func_id, req_sew, req_data0, req_data1);
        else
            e.data = model_bitwise(req_func_id, req_mask, req_be, req_data0, req_data1);
        exp_q.push_back(e);
    endtask

    task automatic check_response();
        resp_t e;
        e = exp_q.pop_front();
        check_value("resp_valid", resp_valid, e.valid);
        if (e.valid) begin
            check_value("resp_data", resp_data, e.data);
            check_value("resp_addr", resp_addr, e.addr);
            check_value("resp_vl", resp_vl, e.vl);
            check_value("resp_be", resp_be, e.be);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        rng_state = 32'ha27b62b6;
        drive_idle();
        repeat (3) exp_q.push_back('0);  // pipeline still empty after reset
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int cyc = 0; cyc < N_REQ + 3; cyc++) begin
            if (cyc < N_REQ)
                drive_random();
            else
                drive_idle();  // drain
            push_expected();
            @(posedge clk);
            #1;
            check_response();
            #1;
        end
        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "errors seen during run");
        end
    end

endmodule

// ==== rtl/valu.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic [`VALU_FUNC_W-1:0] req_func_id,
    input  valu_pkg::sew_t          req_sew,
    input  logic                    req_mask,
    input  logic [`VALU_DATA_W-1:0] req_data0,
    input  logic [`VALU_DATA_W-1:0] req_data1,
    input  logic [`VALU_ADDR_W-1:0] req_addr,
    input  logic [`VALU_VL_W-1:0]   req_vl,
    input  logic [`VALU_BE_W-1:0]   req_be,
    output logic                    resp_valid,
    output logic [`VALU_DATA_W-1:0] resp_data,
    output logic [`VALU_ADDR_W-1:0] resp_addr,
    output logic [`VALU_VL_W-1:0]   resp_vl,
    output logic [`VALU_BE_W-1:0]   resp_be
);
    import valu_pkg::*;

    logic                    arith_start;
    logic                    bit_start;
    arith_op_e               arith_op;
    logic                    arith_signed;
    bit_op_e                 bit_op;
    logic                    arith_done;
    logic [`VALU_DATA_W-1:0] arith_result;
    logic                    bit_done;
    logic [`VALU_DATA_W-1:0] bit_result;
    logic [`VALU_ADDR_W-1:0] addr_d;
    logic [`VALU_VL_W-1:0]   vl_d;
    logic [`VALU_BE_W-1:0]   be_d;

    valu_decode u_decode (
        .func_id      (req_func_id),
        .mask         (req_mask),
        .valid        (req_valid),
        .arith_start  (arith_start),
        .bit_start    (bit_start),
        .arith_op     (arith_op),
        .arith_signed (arith_signed),
        .bit_op       (bit_op)
    );

    valu_add_min_max u_arith (
        .clk       (clk),
        .rst       (rst),
        .start     (arith_start),
        .op        (arith_op),
        .is_signed (arith_signed),
        .sew       (req_sew),
        .data0     (req_data0),
        .data1     (req_data1),
        .done      (arith_done),
        .result    (arith_result)
    );

    valu_bitwise_unit u_bitwise (
        .clk    (clk),
        .rst    (rst),
        .start  (bit_start),
        .op     (bit_op),
        .be     (req_be),  // merge select
        .data0  (req_data0),
        .data1  (req_data1),
        .done   (bit_done),
        .result (bit_result)
    );

    valu_tag_pipe u_tag_pipe (
        .clk    (clk),
        .rst    (rst),
        .addr   (req_addr),
        .vl     (req_vl),
        .be     (req_be),
        .addr_d (addr_d),
        .vl_d   (vl_d),
        .be_d   (be_d)
    );

    valu_resp_merge u_resp_merge (
        .clk          (clk),
        .rst          (rst),
        .arith_done   (arith_done),
        .arith_result (arith_result),
        .bit_done     (bit_done),
        .bit_result   (bit_result),
        .addr_d       (addr_d),
        .vl_d         (vl_d),
        .be_d         (be_d),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .resp_addr    (resp_addr),
        .resp_vl      (resp_vl),
        .resp_be      (resp_be)
    );

endmodule

// ==== rtl/valu_resp_merge.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_resp_merge (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    arith_done,
    input  logic [`VALU_DATA_W-1:0] arith_result,
    input  logic                    bit_done,
    input  logic [`VALU_DATA_W-1:0] bit_result,
    input  logic [`VALU_ADDR_W-1:0] addr_d,
    input  logic [`VALU_VL_W-1:0]   vl_d,
    input  logic [`VALU_BE_W-1:0]   be_d,
    output logic                    resp_valid,
    output logic [`VALU_DATA_W-1:0] resp_data,
    output logic [`VALU_ADDR_W-1:0] resp_addr,
    output logic [`VALU_VL_W-1:0]   resp_vl,
    output logic [`VALU_BE_W-1:0]   resp_be
);

    logic [`VALU_DATA_W-1:0] data_mux;

    // idle unit results hold stale data, mask them off
    assign data_mux = ({`VALU_DATA_W{arith_done}} & arith_result)
                    | ({`VALU_DATA_W{bit_done}} & bit_result);

    always_ff @(posedge clk) begin
        if (rst)
            resp_valid <= 1'b0;
        else
            resp_valid <= arith_done | bit_done;
    end

    always_ff @(posedge clk) begin
        resp_data <= data_mux;
        resp_addr <= addr_d;
        resp_vl   <= vl_d;
        resp_be   <= be_d;
    end

    // equal unit latency keeps results apart, a skew would collide here
    assert property (@(posedge clk) disable iff (rst) !(arith_done && bit_done))
        else $error("valu_resp_merge: unit results collide");

endmodule

// ==== rtl/valu_tag_pipe.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_tag_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`VALU_ADDR_W-1:0] addr,
    input  logic [`VALU_VL_W-1:0]   vl,
    input  logic [`VALU_BE_W-1:0]   be,
    output logic [`VALU_ADDR_W-1:0] addr_d,
    output logic [`VALU_VL_W-1:0]   vl_d,
    output logic [`VALU_BE_W-1:0]   be_d
);

    localparam int DEPTH = `VALU_UNIT_LAT + 1;  // input capture plus unit stages

    logic [`VALU_ADDR_W-1:0] addr_q [DEPTH];
    logic [`VALU_VL_W-1:0]   vl_q   [DEPTH];
    logic [`VALU_BE_W-1:0]   be_q   [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                addr_q[i] <= '0;
                vl_q[i]   <= '0;
                be_q[i]   <= '0;
            end
        end else begin
            addr_q[0] <= addr;
            vl_q[0]   <= vl;
            be_q[0]   <= be;
            for (int i = 1; i < DEPTH; i++) begin
                addr_q[i] <= addr_q[i-1];
                vl_q[i]   <= vl_q[i-1];
                be_q[i]   <= be_q[i-1];
            end
        end
    end

    assign addr_d = addr_q[DEPTH-1];
    assign vl_d   = vl_q[DEPTH-1];
    assign be_d   = be_q[DEPTH-1];

endmodule

// ==== rtl/valu_bitwise_unit.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_bitwise_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  valu_pkg::bit_op_e       op,
    input  logic [`VALU_BE_W-1:0]   be,
    input  logic [`VALU_DATA_W-1:0] data0,
    input  logic [`VALU_DATA_W-1:0] data1,
    output logic                    done,
    output logic [`VALU_DATA_W-1:0] result
);
    import valu_pkg::*;

    logic                    in_vld;
    bit_op_e                 in_op;
    logic [`VALU_BE_W-1:0]   in_be;
    logic [`VALU_DATA_W-1:0] in_a;
    logic [`VALU_DATA_W-1:0] in_b;
    logic [`VALU_DATA_W-1:0] logic_s0;

    logic                    s1_vld;
    logic                    s1_merge;
    logic [`VALU_BE_W-1:0]   s1_be;
    logic [`VALU_DATA_W-1:0] s1_res;
    logic [`VALU_DATA_W-1:0] s1_b;
    logic [`VALU_DATA_W-1:0] res_s1;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_vld <= 1'b0;
            s1_vld <= 1'b0;
            done   <= 1'b0;
        end else begin
            in_vld <= start;
            s1_vld <= in_vld;
            done   <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            in_op <= op;
            in_be <= be;
            in_a  <= data0;
            in_b  <= data1;
        end
        s1_merge <= (in_op == BIT_MERGE);
        s1_be    <= in_be;
        s1_res   <= logic_s0;
        s1_b     <= in_b;
        result   <= res_s1;
    end

    always_comb begin
        case (in_op)
            BIT_AND: logic_s0 = in_a & in_b;
            BIT_OR:  logic_s0 = in_a | in_b;
            BIT_XOR: logic_s0 = in_a ^ in_b;
            default: logic_s0 = in_a;  // move, and merge base
        endcase
    end

    // byte enable set takes data1
    always_comb begin
        res_s1 = s1_res;
        for (int i = 0; i < `VALU_BE_W; i++) begin
            if (s1_merge && s1_be[i])
                res_s1[8*i +: 8] = s1_b[8*i +: 8];
        end
    end

endmodule

// ==== arith/valu_add_min_max.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_add_min_max (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  valu_pkg::arith_op_e     op,
    input  logic                    is_signed,
    input  valu_pkg::sew_t          sew,
    input  logic [`VALU_DATA_W-1:0] data0,
    input  logic [`VALU_DATA_W-1:0] data1,
    output logic                    done,
    output logic [`VALU_DATA_W-1:0] result
);
    import valu_pkg::*;

    localparam int NBYTES = `VALU_DATA_W / 8;

    logic                    in_vld;
    arith_op_e               in_op;
    logic                    in_signed;
    sew_t                    in_sew;
    logic [`VALU_DATA_W-1:0] in_a;
    logic [`VALU_DATA_W-1:0] in_b;
    logic [`VALU_DATA_W-1:0] sum_s0;

    logic                    s1_vld;
    arith_op_e               s1_op;
    logic                    s1_signed;
    sew_t                    s1_sew;
    logic [`VALU_DATA_W-1:0] s1_a;
    logic [`VALU_DATA_W-1:0] s1_b;
    logic [`VALU_DATA_W-1:0] s1_sum;
    logic [`VALU_DATA_W-1:0] res_s1;

    // byte offset mask inside one element
    function automatic logic [2:0] lane_mask(sew_t s);
        case (s)
            `VALU_SEW_8:  return 3'd0;
            `VALU_SEW_16: return 3'd1;
            `VALU_SEW_32: return 3'd3;
            `VALU_SEW_64: return 3'd7;
            default:      return 3'd0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            in_vld <= 1'b0;
            s1_vld <= 1'b0;
            done   <= 1'b0;
        end else begin
            in_vld <= start;
            s1_vld <= in_vld;
            done   <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            in_op     <= op;
            in_signed <= is_signed;
            in_sew    <= sew;
            in_a      <= data0;
            in_b      <= data1;
        end
        s1_op     <= in_op;
        s1_signed <= in_signed;
        s1_sew    <= in_sew;
        s1_a      <= in_a;
        s1_b      <= in_b;
        s1_sum    <= sum_s0;
        result    <= res_s1;
    end

    // byte-sliced adder, carry chain cut at element boundaries
    always_comb begin
        logic       sub;
        logic       carry;
        logic [8:0] part;
        sub   = (in_op != ARITH_ADD);  // min/max compare via a - b
        carry = 1'b0;
        for (int i = 0; i < NBYTES; i++) begin
            if ((3'(i) & lane_mask(in_sew)) == 3'd0)
                carry = sub;
            part = {1'b0, in_a[8*i +: 8]} + {1'b0, in_b[8*i +: 8] ^ {8{sub}}} + 9'(carry);
            sum_s0[8*i +: 8] = part[7:0];
            carry = part[8];
        end
    end

    always_comb begin
        logic [2:0] top;
        logic       a_msb;
        logic       b_msb;
        logic       lt;
        for (int i = 0; i < NBYTES; i++) begin
            top   = 3'(i) | lane_mask(s1_sew);  // top byte of this element
            a_msb = s1_a[8*top + 7];
            b_msb = s1_b[8*top + 7];
            if (a_msb != b_msb)
                lt = s1_signed ? a_msb : b_msb;
            else
                lt = s1_sum[8*top + 7];  // no overflow when signs agree
            case (s1_op)
                ARITH_MIN: res_s1[8*i +: 8] = lt ? s1_a[8*i +: 8] : s1_b[8*i +: 8];
                ARITH_MAX: res_s1[8*i +: 8] = lt ? s1_b[8*i +: 8] : s1_a[8*i +: 8];
                default:   res_s1[8*i +: 8] = s1_sum[8*i +: 8];
            endcase
        end
    end

    // strobe seen before the capture edge, done seen after the output edge
    assert property (@(posedge clk) disable iff (rst) start |-> ##3 done)
        else $error("valu_add_min_max: done missing after start");

endmodule

// ==== rtl/valu_decode.sv ====
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_decode (
    input  logic [`VALU_FUNC_W-1:0] func_id,
    input  logic                    mask,
    input  logic                    valid,
    output logic                    arith_start,
    output logic                    bit_start,
    output valu_pkg::arith_op_e     arith_op,
    output logic                    arith_signed,
    output valu_pkg::bit_op_e       bit_op
);
    import valu_pkg::*;

    unit_e unit_sel;

    always_comb begin
        unit_sel     = UNIT_NONE;  // unknown codes go nowhere
        arith_op     = ARITH_ADD;
        arith_signed = 1'b0;
        bit_op       = BIT_MOVE;
        case (func_id)
            FUNC_ADD: unit_sel = UNIT_ARITH;
            FUNC_SUB: begin
                unit_sel = UNIT_ARITH;
                arith_op = ARITH_SUB;
            end
            FUNC_MINU, FUNC_MIN: begin
                unit_sel     = UNIT_ARITH;
                arith_op     = ARITH_MIN;
                arith_signed = func_id[0];
            end
            FUNC_MAXU, FUNC_MAX: begin
                unit_sel     = UNIT_ARITH;
                arith_op     = ARITH_MAX;
                arith_signed = func_id[0];
            end
            FUNC_AND: begin
                unit_sel = UNIT_BIT;
                bit_op   = BIT_AND;
            end
            FUNC_OR: begin
                unit_sel = UNIT_BIT;
                bit_op   = BIT_OR;
            end
            FUNC_XOR: begin
                unit_sel = UNIT_BIT;
                bit_op   = BIT_XOR;
            end
            FUNC_MV_MERGE: begin
                unit_sel = UNIT_BIT;
                bit_op   = mask ? BIT_MERGE : BIT_MOVE;
            end
            default: unit_sel = UNIT_NONE;
        endcase
    end

    assign arith_start = valid && (unit_sel == UNIT_ARITH);
    assign bit_start   = valid && (unit_sel == UNIT_BIT);

endmodule

// ==== common/valu_pkg.sv ====
`include "valu_consts.svh"

package valu_pkg;

    typedef logic [1:0] sew_t;  // element width code

    typedef enum logic [`VALU_FUNC_W-1:0] {
        FUNC_ADD      = 6'h00,
        FUNC_SUB      = 6'h02,
        FUNC_MINU     = 6'h04,
        FUNC_MIN      = 6'h05,
        FUNC_MAXU     = 6'h06,
        FUNC_MAX      = 6'h07,
        FUNC_AND      = 6'h09,
        FUNC_OR       = 6'h0A,
        FUNC_XOR      = 6'h0B,
        FUNC_MV_MERGE = 6'h17   // req_mask picks merge
    } func_e;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ARITH,
        UNIT_BIT
    } unit_e;

    typedef enum logic [1:0] {
        ARITH_ADD,
        ARITH_SUB,
        ARITH_MIN,
        ARITH_MAX
    } arith_op_e;

    typedef enum logic [2:0] {
        BIT_AND,
        BIT_OR,
        BIT_XOR,
        BIT_MOVE,
        BIT_MERGE
    } bit_op_e;

endpackage

// ==== common/valu_consts.svh ====
`ifndef VALU_CONSTS_SVH
`define VALU_CONSTS_SVH

// datapath and sideband widths
`define VALU_DATA_W     64
`define VALU_ADDR_W     32
`define VALU_VL_W       8
`define VALU_BE_W       8
`define VALU_FUNC_W     6

// register stages behind the operand capture in each unit
`define VALU_UNIT_LAT   2

// element width codes carried on req_sew
`define VALU_SEW_8      2'd0
`define VALU_SEW_16     2'd1
`define VALU_SEW_32     2'd2
`define VALU_SEW_64     2'd3

`endif
